/* bench/ps2_keypad_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_keypad_asserts (
    input logic                clk,
    input logic                rst,
    input logic                scan_valid,
    input logic                scan_err,
    input ps2_pkg::scan_code_t scan_code,
    input logic                key_valid,
    input ps2_pkg::key_code_t  key_code
);
    import ps2_pkg::*;

    key_match_t prev_match; // lookup of the byte one cycle back

    always @(posedge clk)
        prev_match <= key_lookup(scan_code);

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst)
        !(scan_valid && scan_err))
        else $error("scan_valid and scan_err high in the same cycle");

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst)
        scan_valid |=> !scan_valid)
        else $error("scan_valid longer than one cycle");

    a_err_pulse: assert property (@(posedge clk) disable iff (!rst)
        scan_err |=> !scan_err)
        else $error("scan_err longer than one cycle");

    a_key_pulse: assert property (@(posedge clk) disable iff (!rst)
        key_valid |=> !key_valid)
        else $error("key_valid longer than one cycle");

    a_key_after_scan: assert property (@(posedge clk) disable iff (!rst)
        key_valid |-> $past(scan_valid))
        else $error("key_valid without scan_valid in the cycle before");

    a_key_range: assert property (@(posedge clk) disable iff (!rst)
        key_valid |-> (key_code <= KEY_TAB && key_code != 4'd10))
        else $error("key_code out of range");

    // key must match the make table entry
    a_key_table: assert property (@(posedge clk) disable iff (!rst)
        key_valid |-> (prev_match.hit && prev_match.key == key_code))
        else $error("key_code does not match the make table");

endmodule

bind ps2_keypad ps2_keypad_asserts ps2_keypad_asserts_inst (
    .clk        (clk),
    .rst        (rst),
    .scan_valid (scan_valid),
    .scan_err   (scan_err),
    .scan_code  (scan_code),
    .key_valid  (key_valid),
    .key_code   (key_code)
);

`default_nettype wire

/* bench/ps2_vectors.txt */
# byte(hex) corrupt glitch exp_err exp_key_valid exp_key(hex)
# corrupt: 0 none, 1 parity flipped, 2 stop bit 0, 3 start bit 1
45 0 0 0 1 0
16 0 0 0 1 1
1e 0 0 0 1 2
26 0 0 0 1 3
25 0 0 0 1 4
2e 0 0 0 1 5
36 0 0 0 1 6
3d 0 0 0 1 7
3e 0 0 0 1 8
46 0 0 0 1 9
5a 0 0 0 1 b
0d 0 0 0 1 c
f0 0 0 0 0 0
16 0 0 0 0 0
e0 0 0 0 0 0
5a 0 0 0 0 0
e0 0 0 0 0 0
f0 0 0 0 0 0
5a 0 0 0 0 0
45 1 0 1 0 0
16 0 0 0 1 1
26 2 0 1 0 0
2e 3 0 1 0 0
36 0 0 0 1 6
f0 0 0 0 0 0
45 1 0 1 0 0
45 0 0 0 0 0
46 0 0 0 1 9
3d 0 1 0 1 7
5a 0 1 0 1 b
1c 0 0 0 0 0

/* bench/tb_ps2_keypad.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_keypad;
    import ps2_pkg::*;

    localparam int HALF_BIT      = 160;
    localparam int GAP_MIN       = 400;
    localparam int GLITCH_CYCLES = 2 * TICK_DIV;
    localparam int GLITCH_BIT    = 4;
    localparam int GLITCH_HALF   = GLITCH_CYCLES / 2;

    typedef struct packed {
        scan_code_t code;
        logic [1:0] corrupt;
        logic       glitch;
        logic       exp_err;
        logic       exp_key_valid;
        key_code_t  exp_key;
    } vector_t;

    logic        clk = 1'b0;
    logic        rst = 1'b0;
    logic        ps2_clk = 1'b1;
    logic        ps2_data = 1'b1;
    logic        scan_valid;
    logic        scan_err;
    scan_code_t  scan_code;
    logic        key_valid;
    key_code_t   key_code;

    vector_t     vectors [$];
    scan_event_t scan_q [$];
    key_code_t   key_q [$];
    int unsigned cycles = 0;
    int unsigned cycle_limit = 0;
    logic [31:0] rnd_state = 32'd10; // xorshift seed

    ps2_keypad ps2_keypad_inst (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .scan_valid (scan_valid),
        .scan_err   (scan_err),
        .scan_code  (scan_code),
        .key_valid  (key_valid),
        .key_code   (key_code)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic wait_cycles(int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic compare_scan(string name, scan_code_t exp, scan_code_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_key(string name, key_code_t exp, key_code_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic load_vectors();
        int      fd;
        int      n;
        int      code;
        int      corrupt;
        int      glitch;
        int      exp_err;
        int      exp_kv;
        int      exp_key;
        string   line;
        vector_t v;
        fd = $fopen("bench/ps2_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file bench/ps2_vectors.txt");
            abort_run();
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() == 0 || line.getc(0) == "#")
                    continue;
                n = $sscanf(line, "%h %d %d %d %d %h",
                            code, corrupt, glitch, exp_err, exp_kv, exp_key);
                if (n == 6) begin
                    v.code          = scan_code_t'(code);
                    v.corrupt       = 2'(corrupt);
                    v.glitch        = 1'(glitch);
                    v.exp_err       = 1'(exp_err);
                    v.exp_key_valid = 1'(exp_kv);
                    v.exp_key       = key_code_t'(exp_key);
                    vectors.push_back(v);
                end
            end
            $fclose(fd);
        end
    endtask

    // device side of one frame
    task automatic send_frame(vector_t v);
        logic [FRAME_BITS-1:0] bits;
        bits = {1'b1, ~^v.code, v.code, 1'b0}; // stop, odd parity, data, start
        case (v.corrupt)
            2'd1: bits[9] = ~bits[9];
            2'd2: bits[10] = 1'b0;
            2'd3: bits[0] = 1'b1;
            default: ;
        endcase
        @(posedge clk);
        for (int i = 0; i < FRAME_BITS; i++) begin
            ps2_data <= bits[i]; // data changes while the clock is high
            if (v.glitch && i == GLITCH_BIT) begin
                // short pulse straddling the falling clock edge
                wait_cycles(HALF_BIT - GLITCH_HALF);
                ps2_data <= ~bits[i];
                wait_cycles(GLITCH_HALF);
                ps2_clk <= 1'b0;
                wait_cycles(GLITCH_HALF);
                ps2_data <= bits[i];
                wait_cycles(HALF_BIT - GLITCH_HALF);
            end else begin
                wait_cycles(HALF_BIT);
                ps2_clk <= 1'b0;
                wait_cycles(HALF_BIT);
            end
            ps2_clk <= 1'b1;
        end
        ps2_data <= 1'b1; // back to idle
    endtask

    task automatic check_frame(int idx, vector_t v);
        scan_event_t ev;
        if (scan_q.size() != 1) begin
            $display("Frame %0d: expected one scan event, got %0d", idx, scan_q.size());
            abort_run();
        end else begin
            ev = scan_q.pop_front();
            compare_flag("scan_err", v.exp_err, ev.err);
            compare_flag("scan_valid", !v.exp_err, ev.valid);
            if (!v.exp_err)
                compare_scan("scan_code", v.code, ev.code);
            compare_flag("key_valid", v.exp_key_valid, key_q.size() != 0);
            if (key_q.size() > 1) begin
                $display("Frame %0d: got %0d key events, expected one", idx, key_q.size());
                abort_run();
            end else if (key_q.size() == 1) begin
                compare_key("key_code", v.exp_key, key_q.pop_front());
            end
        end
    endtask

    // collect strobes as they come
    always @(posedge clk) begin
        if (rst) begin
            if (scan_valid || scan_err)
                scan_q.push_back(scan_event_t'{valid: scan_valid, err: scan_err,
                                               code: scan_code});
            if (key_valid)
                key_q.push_back(key_code);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not end within %0d clock cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin
        vector_t v;
        int      gap;
        load_vectors();
        cycle_limit = vectors.size() * (22 * HALF_BIT + GAP_MIN) * 2;
        wait_cycles(8);
        rst <= 1'b1;
        wait_cycles(50);
        if (scan_q.size() != 0 || key_q.size() != 0) begin
            $display("Strobes seen after reset before any frame was sent");
            abort_run();
        end
        foreach (vectors[i]) begin
            v = vectors[i];
            send_frame(v);
            rnd_state = xorshift(rnd_state);
            gap = GAP_MIN + int'(rnd_state[6:0]); // shifts the tick phase
            wait_cycles(gap);
            check_frame(i, v);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_ps2_keypad \
    -f src.f \
    -o sim_ps2_keypad

./obj_dir/sim_ps2_keypad

/* src.f */
verilog/ps2_pkg.sv
verilog/ps2_sample_tick.sv
verilog/ps2_line_filter.sv
verilog/ps2_frame_rx.sv
verilog/key_decoder.sv
verilog/ps2_keypad.sv
bench/ps2_keypad_asserts.sv
bench/tb_ps2_keypad.sv

/* verilog/key_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module key_decoder (
    input  logic                 clk,
    input  logic                 rst,
    input  ps2_pkg::scan_event_t scan,
    output logic                 key_valid,
    output ps2_pkg::key_code_t   key_code
);
    import ps2_pkg::*;

    decode_state_t state;
    key_match_t    match;
    logic          make_hit;

    assign match    = key_lookup(scan.code);
    assign make_hit = scan.valid && (state == IDLE) && match.hit;

    // err events leave the state alone
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= IDLE;
            key_valid <= 1'b0;
        end else begin
            key_valid <= make_hit;
            if (scan.valid) begin
                case (state)
                    IDLE: begin
                        if (scan.code == BREAK_PREFIX)
                            state <= BREAK;
                        else if (scan.code == EXT_PREFIX)
                            state <= EXTENDED;
                    end
                    BREAK: begin
                        state <= IDLE; // released key, drop it
                    end
                    EXTENDED: begin
                        if (scan.code == BREAK_PREFIX)
                            state <= BREAK;
                        else
                            state <= IDLE;
                    end
                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

    // last key stays visible
    always_ff @(posedge clk) begin
        if (make_hit)
            key_code <= match.key;
    end

endmodule

`default_nettype wire

/* verilog/ps2_frame_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_frame_rx (
    input  logic                 clk,
    input  logic                 rst,
    input  ps2_pkg::ps2_lines_t  lines,
    output ps2_pkg::scan_event_t scan
);
    import ps2_pkg::*;

    logic       clk_prev;
    logic       fall;
    bit_cnt_t   bit_cnt;
    frame_t     frame;
    frame_t     frame_next;
    logic       last_bit;
    logic       frame_ok;
    logic       valid_q;
    logic       err_q;
    scan_code_t code_q;

    assign fall       = clk_prev & ~lines.clk;
    assign frame_next = {lines.data, frame[FRAME_BITS-1:1]}; // lsb first on the wire
    assign last_bit   = fall && (bit_cnt == bit_cnt_t'(FRAME_BITS - 1));

    // start 0, stop 1, odd parity over data and parity bit
    assign frame_ok = !frame_next[0]
                      && frame_next[FRAME_BITS-1]
                      && (^frame_next[FRAME_BITS-2:1]);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            clk_prev <= 1'b1;
            bit_cnt  <= '0;
            valid_q  <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            clk_prev <= lines.clk;
            valid_q  <= 1'b0;
            err_q    <= 1'b0;
            if (last_bit) begin
                bit_cnt <= '0;
                valid_q <= frame_ok;
                err_q   <= !frame_ok;
            end else if (fall) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall)
            frame <= frame_next;
        if (last_bit)
            code_q <= frame_next[8:1];
    end

    assign scan = '{valid: valid_q, err: err_q, code: code_q};

endmodule

`default_nettype wire

/* verilog/ps2_keypad.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_keypad (
    input  logic                clk,
    input  logic                rst,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output logic                scan_valid,
    output logic                scan_err,
    output ps2_pkg::scan_code_t scan_code,
    output logic                key_valid,
    output ps2_pkg::key_code_t  key_code
);
    import ps2_pkg::*;

    logic        tick;
    ps2_lines_t  lines;
    scan_event_t scan;

    ps2_sample_tick ps2_sample_tick_inst (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    ps2_line_filter ps2_line_filter_inst (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .lines    (lines)
    );

    ps2_frame_rx ps2_frame_rx_inst (
        .clk   (clk),
        .rst   (rst),
        .lines (lines),
        .scan  (scan)
    );

    key_decoder key_decoder_inst (
        .clk       (clk),
        .rst       (rst),
        .scan      (scan),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    assign scan_valid = scan.valid;
    assign scan_err   = scan.err;
    assign scan_code  = scan.code;

endmodule

`default_nettype wire

/* verilog/ps2_line_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_line_filter (
    input  logic              clk,
    input  logic              rst,
    input  logic              tick,
    input  logic              ps2_clk,
    input  logic              ps2_data,
    output ps2_pkg::ps2_lines_t lines
);
    import ps2_pkg::*;

    // index 0 is the clock line, 1 the data line
    filter_hist_t hist [2];
    filter_hist_t hist_next [2];
    logic [1:0]   raw;
    logic [1:0]   filt;

    assign raw = {ps2_data, ps2_clk};

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            hist_next[i] = {hist[i][FILTER_LEN-2:0], raw[i]};
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hist[0] <= '1;
            hist[1] <= '1;
            filt    <= 2'b11; // idle lines are high
        end else if (tick) begin
            for (int i = 0; i < 2; i++) begin
                hist[i] <= hist_next[i];
                if (&hist_next[i])
                    filt[i] <= 1'b1;
                else if (~|hist_next[i])
                    filt[i] <= 1'b0;
            end
        end
    end

    assign lines.clk  = filt[0];
    assign lines.data = filt[1];

endmodule

`default_nettype wire

/* verilog/ps2_pkg.sv */
`default_nettype none

package ps2_pkg;

    localparam int TICK_DIV   = 4;
    localparam int FILTER_LEN = 8;
    localparam int FRAME_BITS = 11;
    localparam int MAKE_KEYS  = 12;

    typedef logic [7:0]                        scan_code_t;
    typedef logic [3:0]                        key_code_t;
    typedef logic [$clog2(TICK_DIV)-1:0]       tick_cnt_t;
    typedef logic [$clog2(FRAME_BITS)-1:0]     bit_cnt_t;
    typedef logic [FRAME_BITS-1:0]             frame_t;
    typedef logic [FILTER_LEN-1:0]             filter_hist_t;

    typedef struct packed {
        logic clk;
        logic data;
    } ps2_lines_t;

    typedef struct packed {
        logic       valid; // good frame strobe
        logic       err;   // bad frame strobe
        scan_code_t code;
    } scan_event_t;

    typedef struct packed {
        scan_code_t code;
        key_code_t  key;
    } make_entry_t;

    typedef struct packed {
        logic      hit;
        key_code_t key;
    } key_match_t;

    typedef enum logic [1:0] {
        IDLE,
        BREAK,
        EXTENDED
    } decode_state_t;

    localparam scan_code_t BREAK_PREFIX = 8'hf0;
    localparam scan_code_t EXT_PREFIX   = 8'he0;
    localparam key_code_t  KEY_ENTER    = 4'd11;
    localparam key_code_t  KEY_TAB      = 4'd12;

    // set 2 make codes of the keypad keys
    localparam make_entry_t MAKE_TABLE [MAKE_KEYS] = '{
        '{8'h45, 4'd0}, '{8'h16, 4'd1}, '{8'h1e, 4'd2}, '{8'h26, 4'd3},
        '{8'h25, 4'd4}, '{8'h2e, 4'd5}, '{8'h36, 4'd6}, '{8'h3d, 4'd7},
        '{8'h3e, 4'd8}, '{8'h46, 4'd9}, '{8'h5a, KEY_ENTER}, '{8'h0d, KEY_TAB}
    };

    function automatic key_match_t key_lookup(scan_code_t code);
        key_match_t m;
        m = '{hit: 1'b0, key: '0};
        for (int i = 0; i < MAKE_KEYS; i++) begin
            if (MAKE_TABLE[i].code == code) begin
                m.hit = 1'b1;
                m.key = MAKE_TABLE[i].key;
            end
        end
        return m;
    endfunction

endpackage

`default_nettype wire

/* verilog/ps2_sample_tick.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_sample_tick (
    input  logic clk,
    input  logic rst,
    output logic tick
);
    import ps2_pkg::*;

    tick_cnt_t cnt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == tick_cnt_t'(TICK_DIV - 1)) begin
            cnt  <= '0;
            tick <= 1'b1; // one pulse per wrap
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire
